// File: Makefile
# Verilator build and run for the SPI byte memory testbench

VERILATOR = verilator
VFLAGS    = --binary -j 0 --timescale 1ns/100ps
TOP       = spiMemoryTb
FILELIST  = list.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
+incdir+verilog
+incdir+testbench
verilog/spiMemPkg.sv
verilog/inputConditioner.sv
verilog/shiftRegister.sv
verilog/dataMemory.sv
verilog/spiController.sv
verilog/spiMemory.sv
testbench/spiMemoryTb.sv

// File: testbench/spiMasterTasks.svh
// SPI mode 0 master tasks for the byte memory testbench, included inside the testbench module

localparam int halfPeriod  = 8;               // clk cycles per sclk half period
localparam int frameGap    = 4 * halfPeriod;  // csN high for 2 sclk periods
localparam int idleTimeout = 64;

// counts clk falling edges, where every pin is driven
task automatic waitCycles(input int n);
    int count;
    count = 0;
    while (count < n) begin
        @(negedge clk);
        count++;
    end
endtask

// slave must release miso before the next frame starts
task automatic waitMisoIdle();
    int cycles;
    cycles = 0;
    while (miso !== 1'b0 && cycles < idleTimeout) begin
        @(negedge clk);
        cycles++;
    end
    if (miso !== 1'b0) begin
        $display("%s: miso was still driven %0d cycles after csN went high",
                 curTest, idleTimeout);
        errorCount++;
        timedOut = 1'b1;
    end
endtask

// one sclk period; mosi changes while sclk is low
task automatic shiftBit(input logic mosiBit, output logic misoBit);
    mosi = mosiBit;
    waitCycles(halfPeriod);
    sclk    = 1'b1;
    misoBit = miso;  // sampled on the rising edge
    waitCycles(halfPeriod);
    sclk = 1'b0;
endtask

// address MSB first, then the r/w bit; miso must stay low throughout
task automatic sendHeader(input addrT addr, input logic readNotWrite);
    logic misoBit;
    waitMisoIdle();
    csN = 1'b0;
    for (int i = `SPI_ADDR_WIDTH - 1; i >= 0; i--) begin
        shiftBit(addr[i], misoBit);
        checkBit($sformatf("%s addr bit %0d", curTest, i), 1'b0, misoBit);
    end
    shiftBit(readNotWrite, misoBit);
    checkBit($sformatf("%s r/w bit", curTest), 1'b0, misoBit);
endtask

task automatic endFrame();
    waitCycles(halfPeriod);
    csN  = 1'b1;
    mosi = 1'b0;
    waitCycles(frameGap);
endtask

task automatic spiWrite(input addrT addr, input byteT data);
    logic misoBit;
    sendHeader(addr, 1'b0);
    for (int i = $bits(byteT) - 1; i >= 0; i--) begin
        shiftBit(data[i], misoBit);
        checkBit($sformatf("%s data bit %0d", curTest, i), 1'b0, misoBit);
    end
    endFrame();
endtask

task automatic spiRead(input addrT addr, output byteT data);
    logic misoBit;
    sendHeader(addr, 1'b1);
    data = '0;
    for (int i = $bits(byteT) - 1; i >= 0; i--) begin
        shiftBit(1'b0, misoBit);
        data[i] = misoBit;
    end
    endFrame();
endtask

// write frame cut short, csN rises after bitsSent data bits
task automatic spiAbort(input addrT addr, input byteT data, input int bitsSent);
    logic misoBit;
    sendHeader(addr, 1'b0);
    for (int n = 0; n < bitsSent; n++) begin
        shiftBit(data[$bits(byteT) - 1 - n], misoBit);
        checkBit($sformatf("%s data bit %0d", curTest, $bits(byteT) - 1 - n),
                 1'b0, misoBit);
    end
    endFrame();
endtask

// File: testbench/spiMemoryTb.sv
// Testbench for the SPI byte memory; runs a table of SPI transactions against a shadow model
`include "spiMem_params.svh"

module spiMemoryTb
    import spiMemPkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum {OpWrite, OpRead, OpAbort} opT;

    logic  clk;
    logic  arstN;
    logic  sclk;
    logic  csN;
    logic  mosi;
    logic  miso;

    int    seed;
    int    errorCount;
    int    failedTests;
    bit    timedOut;
    string curTest;

    // stimulus table, one entry per index
    string names [$];
    opT    ops [$];
    addrT  addrs [$];
    byteT  datas [$];
    byteT  expects [$];
    int    abortBits [$];

    byteT  shadow [`SPI_MEM_DEPTH];  // expected memory contents

    always #4 clk = ~clk;

    spiMemory u_dut (
        .clk   (clk),
        .arstN (arstN),
        .sclk  (sclk),
        .csN   (csN),
        .mosi  (mosi),
        .miso  (miso)
    );

    task automatic checkByte(input string what, input byteT expected, input byteT actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %02h, actual %02h", what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkBit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", what, expected, actual);
            errorCount++;
        end
    endtask

    `include "spiMasterTasks.svh"

    // the model follows writes at build time, aborts leave it alone
    task automatic addEntry(input string name, input opT op, input addrT addr,
                            input byteT data, input int bits);
        if (op == OpWrite) begin
            shadow[addr] = data;
        end
        names.push_back(name);
        ops.push_back(op);
        addrs.push_back(addr);
        datas.push_back(data);
        expects.push_back(shadow[addr]);
        abortBits.push_back(bits);
    endtask

    task automatic buildTable();
        addrT picked [$];
        addrT rndAddr;
        byteT rndData;
        addEntry("wr_basic", OpWrite, 7'h15, 8'hA5, 0);
        addEntry("rd_basic", OpRead, 7'h15, 8'h00, 0);
        for (int i = 0; i < 12; i++) begin
            rndAddr = addrT'($random(seed));
            rndData = byteT'($random(seed));
            picked.push_back(rndAddr);
            addEntry($sformatf("rnd_wr%0d", i), OpWrite, rndAddr, rndData, 0);
        end
        for (int i = 11; i >= 0; i--) begin  // read back in reverse order
            addEntry($sformatf("rnd_rd%0d", i), OpRead, picked[i], 8'h00, 0);
        end
        addEntry("wr_keep", OpWrite, 7'h40, 8'h3C, 0);
        addEntry("abort5", OpAbort, 7'h40, 8'hC3, 5);
        addEntry("rd_keep", OpRead, 7'h40, 8'h00, 0);
        // lowest and highest address, then write followed at once by a read
        addEntry("wr_low", OpWrite, 7'h00, 8'h5A, 0);
        addEntry("wr_high", OpWrite, 7'h7F, 8'h96, 0);
        addEntry("rd_low", OpRead, 7'h00, 8'h00, 0);
        addEntry("rd_high", OpRead, 7'h7F, 8'h00, 0);
        addEntry("wr_b2b", OpWrite, 7'h2B, 8'hE1, 0);
        addEntry("rd_b2b", OpRead, 7'h2B, 8'h00, 0);
    endtask

    task automatic runEntry(input int t);
        byteT rdData;
        int   errorsBefore;
        errorsBefore = errorCount;
        curTest      = names[t];
        rdData       = '0;
        case (ops[t])
            OpWrite: spiWrite(addrs[t], datas[t]);
            OpRead: begin
                spiRead(addrs[t], rdData);
                checkByte(curTest, expects[t], rdData);
            end
            default: spiAbort(addrs[t], datas[t], abortBits[t]);
        endcase
        if (errorCount != errorsBefore) begin
            failedTests++;
        end
        $display("test %s %s addr %02h data %02h: %s", curTest, ops[t].name(), addrs[t],
                 (ops[t] == OpRead) ? rdData : datas[t],
                 (errorCount == errorsBefore) ? "ok" : "failed");
    endtask

    initial begin
        clk         = 1'b0;
        arstN       = 1'b0;
        sclk        = 1'b0;
        csN         = 1'b1;
        mosi        = 1'b0;
        seed        = 32'h9828_c11c;
        errorCount  = 0;
        failedTests = 0;
        timedOut    = 1'b0;
        curTest     = "reset";
        buildTable();
        waitCycles(10);
        arstN = 1'b1;
        waitCycles(4);
        for (int t = 0; t < names.size() && !timedOut; t++) begin
            runEntry(t);
        end
        $display("tests run %0d, tests failed %0d, errors %0d",
                 names.size(), failedTests, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/dataMemory.sv
// Byte storage behind the SPI slave; clocked write, combinational read
`include "spiMem_params.svh"

module dataMemory
    import spiMemPkg::*;
(
    input  logic clk,
    input  logic we,
    input  addrT addr,
    input  byteT writeData,
    output byteT readData
);

    byteT memArray [`SPI_MEM_DEPTH];  // contents undefined until written

    always_ff @(posedge clk) begin
        if (we) begin
            memArray[addr] <= writeData;
        end
    end

    // read port follows the address latch directly
    assign readData = memArray[addr];

endmodule

// File: verilog/inputConditioner.sv
// Synchronizes one asynchronous SPI pin into clk and gives its level and edge pulses
`include "spiMem_params.svh"

module inputConditioner #(
    parameter int stages = `SYNC_STAGES
) (
    input  logic clk,
    input  logic arstN,
    input  logic pin,
    output logic level,
    output logic rise,
    output logic fall
);

    logic [stages-1:0] syncChain;  // bit 0 sees the raw pin
    logic              levelPrev;

    // all stages come out of reset high so an idle-high csN shows no edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncChain <= '1;
            levelPrev <= 1'b1;
        end else begin
            syncChain <= {syncChain[stages-2:0], pin};
            levelPrev <= syncChain[stages-1];
        end
    end

    assign level = syncChain[stages-1];

    // one-cycle pulses, high while the new level differs from the old one
    assign rise = level & ~levelPrev;
    assign fall = ~level & levelPrev;

endmodule

// File: verilog/shiftRegister.sv
// Byte-wide shift register for SPI data, serial in on shiftEn, parallel load from memory
module shiftRegister
    import spiMemPkg::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic shiftEn,     // one-cycle pulse per sclk rising edge
    input  logic serialIn,
    input  logic load,
    input  byteT parallelIn,
    output byteT parallelOut,
    output logic serialOut
);

    byteT shiftData;

    // load beats shift when both arrive in the same cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            shiftData <= '0;
        end else if (load) begin
            shiftData <= parallelIn;
        end else if (shiftEn) begin
            shiftData <= {shiftData[$bits(byteT)-2:0], serialIn};  // MSB first on the wire
        end
    end

    assign parallelOut = shiftData;
    assign serialOut   = shiftData[$bits(byteT)-1];

endmodule

// File: verilog/spiController.sv
// Transaction FSM of the SPI slave; counts sclk edges and issues the datapath strobes
`include "spiMem_params.svh"

module spiController
    import spiMemPkg::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic csSync,    // synchronized csN level
    input  logic csFall,    // start of a transaction
    input  logic sclkRise,  // master has presented a new mosi bit
    input  logic mosiSync,
    output logic addrWe,
    output logic srLoad,
    output logic memWe,
    output logic misoEn
);

    // last bit of the address field and of any 8-bit field
    localparam bitCountT addrLastBit  = bitCountT'(`SPI_ADDR_WIDTH - 1);
    localparam bitCountT fieldLastBit = '1;

    ctrlStateT state;
    bitCountT  bitCount;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= Idle;
            bitCount <= '0;
            addrWe   <= 1'b0;
            srLoad   <= 1'b0;
            memWe    <= 1'b0;
            misoEn   <= 1'b0;
        end else begin
            // strobes are single-cycle unless set below
            addrWe <= 1'b0;
            srLoad <= 1'b0;
            memWe  <= 1'b0;

            if (csSync && state != Idle) begin
                // master released csN so the transaction is dropped without a write
                state  <= Idle;
                misoEn <= 1'b0;
            end else begin
                case (state)
                    Idle: begin
                        if (csFall) begin
                            state    <= GetAddr;
                            bitCount <= '0;
                        end
                    end

                    GetAddr: begin
                        if (sclkRise) begin
                            bitCount <= bitCount + bitCountT'(1);  // wraps into the data field
                            if (bitCount == addrLastBit) begin
                                addrWe <= 1'b1;  // address now sits in sr bits 6:0
                            end
                            if (bitCount == fieldLastBit) begin
                                // eighth bit is r/w where 1 means read
                                if (mosiSync) begin
                                    state  <= ReadLoad;
                                    srLoad <= 1'b1;
                                end else begin
                                    state <= WriteData;
                                end
                            end
                        end
                    end

                    ReadLoad: begin
                        // srLoad is high this cycle and the byte lands in the shift register
                        state  <= ReadData;
                        misoEn <= 1'b1;
                    end

                    ReadData: begin
                        if (sclkRise) begin
                            bitCount <= bitCount + bitCountT'(1);
                            if (bitCount == fieldLastBit) begin
                                state  <= Done;  // bit 0 has been sampled by the master
                                misoEn <= 1'b0;
                            end
                        end
                    end

                    WriteData: begin
                        if (sclkRise) begin
                            bitCount <= bitCount + bitCountT'(1);
                            if (bitCount == fieldLastBit) begin
                                memWe <= 1'b1;  // full byte shifted in
                                state <= Done;
                            end
                        end
                    end

                    Done: begin
                        // no bursts so just wait for csN to go high
                        misoEn <= 1'b0;
                    end

                    default: begin
                        state  <= Idle;
                        misoEn <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

// File: verilog/spiMemPkg.sv
// Shared types for the SPI byte memory, imported by the RTL and the testbench
`include "spiMem_params.svh"

package spiMemPkg;

    typedef logic [`SPI_ADDR_WIDTH-1:0] addrT;  // memory word address
    typedef logic [`SPI_DATA_WIDTH-1:0] byteT;  // data byte / shift register contents

    // bit position inside the current 8-bit field
    typedef logic [$clog2(`SPI_DATA_WIDTH)-1:0] bitCountT;

    // transaction controller states
    typedef enum logic [2:0] {
        Idle,       // csN high, waiting for a transaction
        GetAddr,    // shifting in address and r/w bit
        ReadLoad,   // loading memory byte into the shift register
        ReadData,   // shifting the byte out on miso
        WriteData,  // shifting the write byte in
        Done        // field complete, wait for csN to rise
    } ctrlStateT;

endpackage

// File: verilog/spiMem_params.svh
// Sizing macros for the SPI byte memory; include wherever a width or depth is needed
`ifndef SPI_MEM_PARAMS_SVH
`define SPI_MEM_PARAMS_SVH

// memory geometry
`define SPI_ADDR_WIDTH 7
`define SPI_DATA_WIDTH 8
`define SPI_MEM_DEPTH  128

// flops per pin synchronizer, 3 also works
`define SYNC_STAGES    2

`endif

// File: verilog/spiMemory.sv
// Top level of the SPI-attached byte memory; mode 0 slave with a 128 x 8 array
`include "spiMem_params.svh"

module spiMemory
    import spiMemPkg::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic sclk,
    input  logic csN,
    input  logic mosi,
    output logic miso
);

    logic sclkRise;
    logic sclkFall;
    logic csSync;
    logic csFall;
    logic mosiSync;

    logic addrWe;
    logic srLoad;
    logic memWe;
    logic misoEn;

    byteT srData;
    logic srMsb;
    byteT memReadData;
    addrT addrLatch;

    // pin conditioning, all three pins see the same latency
    inputConditioner u_sclkCond (
        .clk   (clk),
        .arstN (arstN),
        .pin   (sclk),
        .level (),
        .rise  (sclkRise),
        .fall  (sclkFall)
    );

    inputConditioner u_csCond (
        .clk   (clk),
        .arstN (arstN),
        .pin   (csN),
        .level (csSync),
        .rise  (),
        .fall  (csFall)
    );

    inputConditioner u_mosiCond (
        .clk   (clk),
        .arstN (arstN),
        .pin   (mosi),
        .level (mosiSync),
        .rise  (),
        .fall  ()
    );

    shiftRegister u_shiftReg (
        .clk         (clk),
        .arstN       (arstN),
        .shiftEn     (sclkRise),
        .serialIn    (mosiSync),
        .load        (srLoad),
        .parallelIn  (memReadData),
        .parallelOut (srData),
        .serialOut   (srMsb)
    );

    // address is captured after the seventh bit, before the r/w bit shifts in
    always_ff @(posedge clk) begin
        if (addrWe) begin
            addrLatch <= srData[`SPI_ADDR_WIDTH-1:0];
        end
    end

    dataMemory u_mem (
        .clk       (clk),
        .we        (memWe),
        .addr      (addrLatch),
        .writeData (srData),
        .readData  (memReadData)
    );

    spiController u_ctrl (
        .clk      (clk),
        .arstN    (arstN),
        .csSync   (csSync),
        .csFall   (csFall),
        .sclkRise (sclkRise),
        .mosiSync (mosiSync),
        .addrWe   (addrWe),
        .srLoad   (srLoad),
        .memWe    (memWe),
        .misoEn   (misoEn)
    );

    // miso changes on sclk falling edges so the master can sample on the rise
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            miso <= 1'b0;
        end else if (!misoEn) begin
            miso <= 1'b0;
        end else if (sclkFall) begin
            miso <= srMsb;
        end
    end

endmodule
